// ==== hdl/uart_cfg_pkg.sv ====
`default_nettype none
// ========================================
// UART line framing definitions
// Parity mode and received frame layout
// ========================================

package uart_cfg_pkg;

    // Data bits per character sent LSB first on the line
    localparam int DATA_BITS = 8;

    // Parity sense applied to data plus parity bit
    typedef enum logic
    {
        PARITY_EVEN = 1'b0,                 // Even count of ones
        PARITY_ODD  = 1'b1                  // Odd count of ones
    } parity_mode_e;

    // One received character as the receiver hands it on
    typedef struct packed
    {
        logic [DATA_BITS-1:0] data;         // Rebuilt data byte
        logic                 parity_error; // Parity bit disagreed
    } rx_frame_t;

endpackage

`default_nettype wire

// ==== hdl/buffer_pkg.sv ====
`default_nettype none
// ========================================
// Channel and buffer entry definitions
// ========================================

package buffer_pkg;

    // Serial inputs feeding the shared buffer
    localparam int NUM_CHANNELS = 2;

    // Channel index carried with every entry
    typedef logic [$clog2(NUM_CHANNELS)-1:0] chan_id_t;

    // One tagged entry as stored and sent to the host
    typedef struct packed
    {
        chan_id_t   chan;                   // Source channel
        logic [7:0] data;                   // Received byte
        logic       parity_error;           // Parity check failed
        logic       overrun;                // A later frame was dropped
    } buf_entry_t;

endpackage

`default_nettype wire

// ==== hdl/uart_rx.sv ====
`timescale 1ns/10ps
`default_nettype none
// ========================================
// UART receiver
// Mid-bit sampling of start, data, parity and stop
// ========================================

module uart_rx
    import uart_cfg_pkg::*;
#(
    parameter int           CLKS_PER_BIT = 16,
    parameter parity_mode_e PARITY_MODE  = PARITY_EVEN
)
(
    input  wire       clk,
    input  wire       reset,
    input  wire       rx,
    output logic      frame_valid,
    output rx_frame_t frame
);

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam int HALF  = CLKS_PER_BIT / 2;
    localparam int IDX_W = $clog2(DATA_BITS);

    typedef enum logic [2:0]
    {
        S_IDLE,
        S_START,
        S_DATA,
        S_PARITY,
        S_STOP
    } state_t;

    state_t               state_q;
    logic                 rx_meta;          // First sync stage
    logic                 rx_sync;          // Safe to use
    logic                 rx_prev;          // For falling edge detect
    logic [CNT_W-1:0]     cnt_q;            // Cycles within a bit period
    logic [IDX_W-1:0]     bit_idx_q;
    logic                 parity_acc_q;     // XOR of data bits so far
    logic [DATA_BITS-1:0] shift_q;
    logic                 perr_q;
    logic                 half_tick;
    logic                 bit_tick;

    assign half_tick = (cnt_q == CNT_W'(HALF - 1));
    assign bit_tick  = (cnt_q == CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            rx_meta      <= 1'b1;
            rx_sync      <= 1'b1;
            rx_prev      <= 1'b1;
            state_q      <= S_IDLE;
            cnt_q        <= '0;
            bit_idx_q    <= '0;
            parity_acc_q <= 1'b0;
            frame_valid  <= 1'b0;
        end
        else
        begin
            rx_meta     <= rx;
            rx_sync     <= rx_meta;
            rx_prev     <= rx_sync;
            frame_valid <= 1'b0;
            cnt_q       <= cnt_q + 1'b1;
            case (state_q)
                S_IDLE:
                begin
                    cnt_q <= '0;
                    // A line held low after a bad stop bit gives no edge here
                    if (rx_prev && !rx_sync)
                        state_q <= S_START;
                end
                S_START:
                begin
                    if (half_tick)
                    begin
                        cnt_q        <= '0;
                        bit_idx_q    <= '0;
                        parity_acc_q <= 1'b0;
                        state_q      <= rx_sync ? S_IDLE : S_DATA;  // Glitch rejected
                    end
                end
                S_DATA:
                begin
                    if (bit_tick)
                    begin
                        cnt_q        <= '0;
                        parity_acc_q <= parity_acc_q ^ rx_sync;
                        bit_idx_q    <= bit_idx_q + 1'b1;
                        if (bit_idx_q == IDX_W'(DATA_BITS - 1))
                            state_q <= S_PARITY;
                    end
                end
                S_PARITY:
                begin
                    if (bit_tick)
                    begin
                        cnt_q   <= '0;
                        state_q <= S_STOP;
                    end
                end
                default:
                begin
                    if (bit_tick)
                    begin
                        cnt_q       <= '0;
                        state_q     <= S_IDLE;
                        frame_valid <= rx_sync;     // Low stop bit drops the frame
                    end
                end
            endcase
        end
    end

    // Byte and parity result for the next frame_valid pulse
    always_ff @(posedge clk)
    begin
        if (state_q == S_DATA && bit_tick)
            shift_q <= {rx_sync, shift_q[DATA_BITS-1:1]};   // LSB arrives first
        if (state_q == S_PARITY && bit_tick)
            perr_q <= parity_acc_q ^ rx_sync ^ (PARITY_MODE == PARITY_ODD);
    end

    assign frame.data         = shift_q;
    assign frame.parity_error = perr_q;

endmodule

`default_nettype wire

// ==== hdl/rx_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none
// ========================================
// Receive arbiter
// Pending slot per channel, round-robin write
// ========================================

module rx_arbiter
    import uart_cfg_pkg::*, buffer_pkg::*;
(
    input  wire                                  clk,
    input  wire                                  reset,
    input  wire        [NUM_CHANNELS-1:0]        frame_valid,
    input  wire rx_frame_t [NUM_CHANNELS-1:0]    frame,
    input  wire                                  full,
    output logic                                 wr_en,
    output buf_entry_t                           wr_entry
);

    rx_frame_t [NUM_CHANNELS-1:0] slot_q;
    logic      [NUM_CHANNELS-1:0] pending_q;
    logic      [NUM_CHANNELS-1:0] overrun_q;
    chan_id_t                     last_q;       // Previous winner
    chan_id_t                     grant_idx;
    logic                         grant_valid;

    // Search starts with the channel after the last winner
    always_comb
    begin
        int idx;
        grant_valid = 1'b0;
        grant_idx   = last_q;
        for (int k = 1; k <= NUM_CHANNELS; k++)
        begin
            idx = (int'(last_q) + k) % NUM_CHANNELS;
            if (!grant_valid && pending_q[idx])
            begin
                grant_valid = 1'b1;
                grant_idx   = chan_id_t'(idx);
            end
        end
    end

    assign wr_en                 = grant_valid && !full;
    assign wr_entry.chan         = grant_idx;
    assign wr_entry.data         = slot_q[grant_idx].data;
    assign wr_entry.parity_error = slot_q[grant_idx].parity_error;
    assign wr_entry.overrun      = overrun_q[grant_idx];

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            pending_q <= '0;
            overrun_q <= '0;
            last_q    <= chan_id_t'(NUM_CHANNELS - 1);   // Channel 0 first
        end
        else
        begin
            if (wr_en)
                last_q <= grant_idx;
            for (int i = 0; i < NUM_CHANNELS; i++)
            begin
                if (frame_valid[i] && (!pending_q[i] || (wr_en && grant_idx == chan_id_t'(i))))
                begin
                    pending_q[i] <= 1'b1;
                    overrun_q[i] <= 1'b0;
                end
                else if (frame_valid[i])
                    overrun_q[i] <= 1'b1;       // New frame lost, old one kept
                else if (wr_en && grant_idx == chan_id_t'(i))
                begin
                    pending_q[i] <= 1'b0;
                    overrun_q[i] <= 1'b0;
                end
            end
        end
    end

    // Slot payload loads only into a free or departing slot
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < NUM_CHANNELS; i++)
        begin
            if (frame_valid[i] && (!pending_q[i] || (wr_en && grant_idx == chan_id_t'(i))))
                slot_q[i] <= frame[i];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/frame_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none
// ========================================
// Shared frame buffer
// Ring memory drained under host credits
// ========================================

module frame_buffer
    import buffer_pkg::*;
#(
    parameter int BUF_DEPTH   = 4,
    parameter int OUT_CREDITS = 2
)
(
    input  wire             clk,
    input  wire             reset,
    input  wire             wr_en,
    input  wire buf_entry_t wr_entry,
    output logic            full,
    input  wire             credit_return,
    output logic            out_valid,
    output buf_entry_t      out_entry
);

    localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
    localparam int CNT_W = $clog2(BUF_DEPTH + 1);
    localparam int CRD_W = $clog2(OUT_CREDITS + 1);

    buf_entry_t       mem_q [BUF_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;              // Entries held
    logic [CRD_W-1:0] credits_q;            // Entries the host can still take

    assign full      = (count_q == CNT_W'(BUF_DEPTH));
    assign out_valid = (count_q != '0) && (credits_q != '0);
    assign out_entry = mem_q[rd_ptr_q];     // Head of the ring

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem_q[wr_ptr_q] <= wr_entry;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end
        else
        begin
            // Power-of-two depth lets the pointers wrap on their own
            if (wr_en)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (out_valid)
                rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            count_q <= '0;
        else
        begin
            case ({wr_en, out_valid})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;            // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            credits_q <= CRD_W'(OUT_CREDITS);
        else
        begin
            case ({credit_return, out_valid})
                2'b10:   credits_q <= credits_q + 1'b1;
                2'b01:   credits_q <= credits_q - 1'b1;
                default: credits_q <= credits_q;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/uart_concentrator.sv ====
`timescale 1ns/10ps
`default_nettype none
// ========================================
// Two-channel UART receive concentrator
// Receivers feed one shared tagged buffer
// ========================================

module uart_concentrator
    import uart_cfg_pkg::*, buffer_pkg::*;
#(
    parameter int           CLKS_PER_BIT = 16,
    parameter parity_mode_e PARITY_MODE  = PARITY_EVEN,
    parameter int           BUF_DEPTH    = 4,
    parameter int           OUT_CREDITS  = 2
)
(
    input  wire                    clk,
    input  wire                    reset,
    input  wire [NUM_CHANNELS-1:0] rx,
    input  wire                    credit_return,
    output logic                   out_valid,
    output buf_entry_t             out_entry
);

    logic      [NUM_CHANNELS-1:0] frame_valid;
    rx_frame_t [NUM_CHANNELS-1:0] frame;
    logic                         wr_en;
    buf_entry_t                   wr_entry;
    logic                         full;

    // One receiver per serial line
    for (genvar i = 0; i < NUM_CHANNELS; i++)
    begin : g_rx
        uart_rx #(
            .CLKS_PER_BIT (CLKS_PER_BIT),
            .PARITY_MODE  (PARITY_MODE)
        ) u_uart_rx (
            .clk         (clk),
            .reset       (reset),
            .rx          (rx[i]),
            .frame_valid (frame_valid[i]),
            .frame       (frame[i])
        );
    end

    rx_arbiter u_rx_arbiter (
        .clk         (clk),
        .reset       (reset),
        .frame_valid (frame_valid),
        .frame       (frame),
        .full        (full),
        .wr_en       (wr_en),
        .wr_entry    (wr_entry)
    );

    frame_buffer #(
        .BUF_DEPTH   (BUF_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_frame_buffer (
        .clk           (clk),
        .reset         (reset),
        .wr_en         (wr_en),
        .wr_entry      (wr_entry),
        .full          (full),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_entry     (out_entry)
    );

endmodule

`default_nettype wire

// ==== bench/uart_concentrator_tb.sv ====
`timescale 1ns/10ps
`default_nettype none
// ========================================
// Testbench for the UART concentrator
// Serial drivers, host credit model, scoreboard
// ========================================

module uart_concentrator_tb
    import uart_cfg_pkg::*, buffer_pkg::*;
();

    localparam int           CLKS_PER_BIT   = 8;
    localparam parity_mode_e PARITY_MODE    = PARITY_EVEN;
    localparam int           BUF_DEPTH      = 4;
    localparam int           OUT_CREDITS    = 2;
    localparam int           TOTAL_FRAMES   = 6 + 4 + 2 + 12 + 4 + 9;     // Summed over six tests
    localparam int           TIMEOUT_CYCLES = TOTAL_FRAMES * 11 * CLKS_PER_BIT * 3 / 2;

    logic                    clk = 1'b0;
    logic                    reset;
    logic [NUM_CHANNELS-1:0] rx;
    logic                    credit_return;
    logic                    out_valid;
    buf_entry_t              out_entry;

    buf_entry_t exp_q [NUM_CHANNELS][$];    // Expected entries per channel
    int         total_out;                  // Entries taken by the host
    int         total_ret;                  // Credits handed back
    logic       withhold;                   // Host keeps its credits
    int         cycles       = 0;
    int         errors       = 0;
    int         test_errors  = 0;
    int         tests_run    = 0;
    int         tests_failed = 0;

    uart_concentrator #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .PARITY_MODE  (PARITY_MODE),
        .BUF_DEPTH    (BUF_DEPTH),
        .OUT_CREDITS  (OUT_CREDITS)
    ) dut0 (
        .clk           (clk),
        .reset         (reset),
        .rx            (rx),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_entry     (out_entry)
    );

    always #20 clk = ~clk;

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("Run timed out after %0d cycles, entries still missing", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    always @(posedge clk)
    begin
        if (reset)
        begin
            total_out <= 0;
            total_ret <= 0;
        end
        else
        begin
            if (out_valid)
                total_out <= total_out + 1;
            if (credit_return)
                total_ret <= total_ret + 1;
        end
    end

    // Host hands credits back at random intervals unless told to hold them
    initial
    begin
        credit_return = 1'b0;
        forever
        begin
            @(negedge clk);
            credit_return = 1'b0;
            if (!reset && !withhold && total_out > total_ret && ($urandom % 3) == 0)
                credit_return = 1'b1;
        end
    end

    // Channel order is free, so each entry is matched against its own channel queue
    always @(posedge clk)
    begin
        buf_entry_t exp;
        if (!reset && out_valid)
        begin
            assert (exp_q[out_entry.chan].size() != 0)
            else
            begin
                $display("ERR %0t: entry on channel %0d with no frame outstanding",
                         $time, out_entry.chan);
                errors++;
            end
            if (exp_q[out_entry.chan].size() != 0)
            begin
                exp = exp_q[out_entry.chan].pop_front();
                assert (out_entry == exp)
                else
                begin
                    $display("ERR %0t: chan %0d got %02h perr %0b ovr %0b,",
                             $time, out_entry.chan, out_entry.data, out_entry.parity_error,
                             out_entry.overrun,
                             " expected %02h perr %0b ovr %0b",
                             exp.data, exp.parity_error, exp.overrun);
                    errors++;
                end
            end
        end
    end

    credit_gate: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> (total_out - total_ret) < OUT_CREDITS)
    else
    begin
        $display("ERR %0t: out_valid while the host held every credit", $time);
        errors++;
    end

    credit_bound: assert property (@(posedge clk) disable iff (reset)
        total_out <= OUT_CREDITS + total_ret)
    else
    begin
        $display("ERR %0t: %0d entries sent against %0d credits", $time, total_out,
                 OUT_CREDITS + total_ret);
        errors++;
    end

    // Drives start, 8 data bits LSB first, parity and stop for one bit period each
    task automatic send_frame(input int ch, input logic [7:0] data, input bit bad_parity,
                              input bit bad_stop, input bit expect_it);
        buf_entry_t  e;
        logic [10:0] bits;
        e.chan         = chan_id_t'(ch);
        e.data         = data;
        e.parity_error = bad_parity;
        e.overrun      = 1'b0;
        if (expect_it)
            exp_q[ch].push_back(e);
        bits = {~bad_stop, (^data) ^ bad_parity, data, 1'b0};   // Even rule on good frames
        for (int i = 0; i < 11; i++)
        begin
            @(negedge clk);
            rx[ch] = bits[i];
            repeat (CLKS_PER_BIT - 1) @(negedge clk);
        end
        if (bad_stop)
        begin
            @(negedge clk);
            rx[ch] = 1'b1;                  // Line back to idle
            repeat (CLKS_PER_BIT - 1) @(negedge clk);
        end
    endtask

    task automatic mark_overrun(input int ch);
        buf_entry_t e;
        e         = exp_q[ch].pop_back();
        e.overrun = 1'b1;
        exp_q[ch].push_back(e);
    endtask

    task automatic wait_drain();
        while (exp_q[0].size() != 0 || exp_q[1].size() != 0)
            @(posedge clk);
        repeat (4 * CLKS_PER_BIT) @(negedge clk);   // Room for a stray entry to show
    endtask

    task automatic wait_credits();
        while (total_out != total_ret)
            @(posedge clk);
        @(negedge clk);
    endtask

    task automatic finish_test(input string name);
        int n;
        n = errors - test_errors;
        tests_run++;
        if (n != 0)
            tests_failed++;
        $display("Test %0d %s: %0d errors", tests_run, name, n);
        test_errors = errors;
    endtask

    initial
    begin
        logic [7:0] bytes0 [6];
        logic [7:0] bytes1 [6];
        void'($urandom(55));
        reset    = 1'b1;
        rx       = '1;
        withhold = 1'b0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        repeat (2) @(negedge clk);

        for (int i = 0; i < 6; i++)
            send_frame(0, 8'($urandom), 1'b0, 1'b0, 1'b1);
        wait_drain();
        finish_test("single channel");

        send_frame(0, 8'h00, 1'b0, 1'b0, 1'b1);
        send_frame(0, 8'h00, 1'b1, 1'b0, 1'b1);
        send_frame(1, 8'hA5, 1'b1, 1'b0, 1'b1);
        send_frame(1, 8'h7F, 1'b0, 1'b0, 1'b1);
        wait_drain();
        finish_test("parity");

        send_frame(1, 8'h3C, 1'b0, 1'b1, 1'b0);  // Dropped by the receiver
        send_frame(1, 8'hC3, 1'b0, 1'b0, 1'b1);
        wait_drain();
        finish_test("bad stop bit");

        for (int i = 0; i < 6; i++)
        begin
            bytes0[i] = 8'($urandom);
            bytes1[i] = 8'($urandom);
        end
        fork
            for (int i = 0; i < 6; i++)
                send_frame(0, bytes0[i], 1'b0, 1'b0, 1'b1);
            for (int j = 0; j < 6; j++)
                send_frame(1, bytes1[j], 1'b0, 1'b0, 1'b1);
        join
        wait_drain();
        finish_test("both channels");

        wait_credits();
        withhold = 1'b1;
        for (int i = 0; i < 4; i++)
            send_frame(1, 8'($urandom), 1'b0, 1'b0, 1'b1);
        repeat (4 * CLKS_PER_BIT) @(negedge clk);
        assert (total_out - total_ret == OUT_CREDITS && exp_q[1].size() == 2)
        else
        begin
            $display("Buffer did not hold its entries while the host kept its credits");
            errors++;
        end
        withhold = 1'b0;
        wait_drain();
        finish_test("credits");

        // Two leave on the initial credits, four fill the buffer, two wait in the slots
        wait_credits();
        withhold = 1'b1;
        fork
            for (int i = 0; i < 4; i++)
                send_frame(0, bytes1[i], 1'b0, 1'b0, 1'b1);
            for (int j = 0; j < 4; j++)
                send_frame(1, bytes0[j], 1'b0, 1'b0, 1'b1);
        join
        repeat (2 * CLKS_PER_BIT) @(negedge clk);
        send_frame(0, 8'h5A, 1'b0, 1'b0, 1'b0);
        mark_overrun(0);
        repeat (2 * CLKS_PER_BIT) @(negedge clk);
        assert (exp_q[0].size() + exp_q[1].size() == 6)
        else
        begin
            $display("Expected six entries held before credits return, model has %0d",
                     exp_q[0].size() + exp_q[1].size());
            errors++;
        end
        withhold = 1'b0;
        wait_drain();
        finish_test("overrun");

        $display("Tests run %0d, failed %0d, error count %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
hdl/uart_cfg_pkg.sv
hdl/buffer_pkg.sv
hdl/uart_rx.sv
hdl/rx_arbiter.sv
hdl/frame_buffer.sv
hdl/uart_concentrator.sv
bench/uart_concentrator_tb.sv
